// ==== Makefile ====
OBJ = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f \
		--top-module pm_msg_tb -Mdir $(OBJ) -o pm_msg_tb

run: compile
	./$(OBJ)/pm_msg_tb +verilator+error+limit+100 | tee sim.log
	grep -q "^\*\* PASS \*\*$$" sim.log

clean:
	rm -rf $(OBJ) sim.log

// ==== list.f ====
+incdir+logic
logic/pm_msg_pkg.sv
logic/msg_fifo.sv
logic/msg_node.sv
logic/pm_msg_port.sv
logic/pm_msg_top.sv
tests/pm_msg_sva.sv
tests/pm_msg_tb.sv

// ==== logic/msg_fifo.sv ====
`timescale 1ns/1ps

module msg_fifo
#(
	parameter int ADR_BITS = 5	// Depth is 2**ADR_BITS
)
(
	input logic RST_IN,
	input logic CLK_IN,
	input logic clr,		// Synchronous flush
	input logic wr,
	input pm_msg_pkg::fifo_dat_t din,
	input logic rd,
	output pm_msg_pkg::fifo_dat_t dout,	// Head word, fall through
	output logic de,		// Head word valid
	output logic [ADR_BITS:0] wrds,
	output logic ep,
	output logic fl
);
	import pm_msg_pkg::*;

	localparam int WRDS = 2**ADR_BITS;

	fifo_dat_t mem [WRDS];		// Storage
	logic [ADR_BITS:0] wp;		// Write pointer, extra wrap bit
	logic [ADR_BITS:0] rp;		// Read pointer
	logic do_wr;
	logic do_rd;

	// Full drops the write, empty ignores the read
	assign do_wr = wr && !fl;
	assign do_rd = rd && !ep;

	// Storage write
	always_ff @(posedge CLK_IN)
	begin
		if (do_wr)
			mem[wp[ADR_BITS-1:0]] <= din;
	end

	// Pointers
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
		begin
			wp <= '0;
			rp <= '0;
		end
		else if (clr)
		begin
			wp <= '0;	// Flush
			rp <= '0;
		end
		else
		begin
			if (do_wr)
				wp <= wp + 1'b1;
			if (do_rd)
				rp <= rp + 1'b1;
		end
	end

	// Fill level
	assign wrds = wp - rp;		// Wrap bit keeps this exact
	assign ep = (wrds == '0);
	assign fl = (wrds == WRDS);

	// Read side
	assign dout = mem[rp[ADR_BITS-1:0]];	// First word falls through
	assign de = !ep;

endmodule

// ==== logic/msg_node.sv ====
`timescale 1ns/1ps
`include "pm_msg_params.svh"

module msg_node
#(
	parameter int ID = 0		// Matched against header bits 13:8
)
(
	input logic RST_IN,
	input logic CLK_IN,

	// Upstream
	input logic in_vld,
	input logic in_som,
	input logic in_eom,
	input pm_msg_pkg::msg_dat_t in_dat,

	// Downstream
	output logic out_vld,
	output logic out_som,
	output logic out_eom,
	output pm_msg_pkg::msg_dat_t out_dat
);
	import pm_msg_pkg::*;

	localparam int REGS = `PM_MSG_NODE_REGS;
	localparam int IDX = (REGS > 1) ? $clog2(REGS) : 1;

	msg_dat_t regs [REGS];		// Register file
	node_state_t state;		// Body handling, set by the header
	node_state_t hdr_state;		// Decision for an arriving header
	node_state_t cur_state;		// Applies to the word at the input
	reg_adr_t adr_r;		// Latched register address
	logic wr_r;			// Write request in progress
	logic hdr_hit;			// Request addressed to this node
	logic hdr_ok;			// Address inside the register file
	logic body_wr;

	// Header decode
	assign hdr_hit = in_vld && in_som && in_dat[15] && (in_dat[13:8] == node_id_t'(ID));
	assign hdr_ok = (in_dat[7:0] < REGS);

	always_comb
	begin
		hdr_state = node_pass;
		if (hdr_hit && !in_dat[14])		// Read request
			hdr_state = hdr_ok ? node_reply : node_drop;
	end

	assign cur_state = in_som ? hdr_state : state;

	// Message context
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
		begin
			state <= node_pass;
			wr_r <= 1'b0;
		end
		else if (in_vld && in_som)
		begin
			state <= hdr_state;
			wr_r <= hdr_hit && in_dat[14];
		end
		else if (in_vld && in_eom)
		begin
			state <= node_pass;		// Message done
			wr_r <= 1'b0;
		end
	end

	always_ff @(posedge CLK_IN)
	begin
		if (hdr_hit)
			adr_r <= in_dat[7:0];
	end

	// Register write from the body of a write request
	assign body_wr = in_vld && !in_som && wr_r && (adr_r < REGS);

	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
		begin
			for (int i = 0; i < REGS; i++)
				regs[i] <= '0;
		end
		else if (body_wr)
			regs[adr_r[IDX-1:0]] <= in_dat;
	end

	// Output stage, one cycle per node
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
			out_vld <= 1'b0;
		else
			out_vld <= in_vld && (cur_state != node_drop);
	end

	always_ff @(posedge CLK_IN)
	begin
		out_som <= in_som;
		out_eom <= in_eom;
		if (cur_state == node_reply)
			out_dat <= in_som ? {1'b0, in_dat[14:0]} : regs[adr_r[IDX-1:0]];	// Reply
		else
			out_dat <= in_dat;
	end

endmodule

// ==== logic/pm_msg_params.svh ====
`ifndef PM_MSG_PARAMS_SVH
`define PM_MSG_PARAMS_SVH

// Ring size
`define PM_MSG_NODES		4	// Number of nodes in the ring

// Register file per node
`define PM_MSG_NODE_REGS	4	// Registers in each node

// Port RX FIFO
`define PM_MSG_FIFO_WRDS	32	// Depth, power of two

// Reply timeout
// Counter is loaded with all ones on every TX word
`define PM_MSG_TO_BITS		8	// Timeout counter width

`endif

// ==== logic/pm_msg_pkg.sv ====
package pm_msg_pkg;

	// Ring word
	// Header layout is req[15], wr[14], id[13:8], adr[7:0]
	typedef logic [15:0] msg_dat_t;

	// Local bus
	typedef logic [2:0] lb_adr_t;	// Register address
	typedef logic [31:0] lb_dat_t;	// Bus data

	// Header fields
	typedef logic [5:0] node_id_t;	// Node id
	typedef logic [7:0] reg_adr_t;	// Node register address

	// RX FIFO word
	// som in bit 17, eom in bit 16, data below
	typedef logic [17:0] fifo_dat_t;

	// Node body handling
	typedef enum logic [1:0]
	{
		node_pass,	// Forward untouched
		node_reply,	// Swap body for register value
		node_drop	// Swallow the word
	} node_state_t;

endpackage

// ==== logic/pm_msg_port.sv ====
`timescale 1ns/1ps
`include "pm_msg_params.svh"

module pm_msg_port
(
	input logic RST_IN,
	input logic CLK_IN,

	// Local bus
	input pm_msg_pkg::lb_adr_t lb_adr,
	input logic lb_wr,
	input logic lb_rd,
	input pm_msg_pkg::lb_dat_t lb_din,
	output pm_msg_pkg::lb_dat_t lb_dout,
	output logic lb_vld,

	// Ring source, towards node 0
	output logic src_vld,
	output logic src_som,
	output logic src_eom,
	output pm_msg_pkg::msg_dat_t src_dat,

	// Ring sink, from the last node
	input logic snk_vld,
	input logic snk_som,
	input logic snk_eom,
	input pm_msg_pkg::msg_dat_t snk_dat,

	output logic irq
);
	import pm_msg_pkg::*;

	localparam int RX_ADR = $clog2(`PM_MSG_FIFO_WRDS);
	localparam int STA_W = 5 + RX_ADR;	// irq, to, ep, fl, words

	// Registered bus
	lb_adr_t lb_adr_r;
	logic lb_wr_r;
	logic lb_rd_r;
	lb_dat_t lb_din_r;

	// Address decode
	logic ctl_sel;
	logic sta_sel;
	logic tx_sel;
	logic rx_sel;

	// Control and status
	logic [1:0] ctl_r;
	logic run;
	logic ie;
	logic [STA_W-1:0] sta;
	logic irq_r;

	// Timeout
	logic [`PM_MSG_TO_BITS-1:0] to_cnt;
	logic to_end;			// Counter at zero
	logic to_end_d;
	logic to_end_re;		// Counter just reached zero
	logic to_en;			// Reply pending
	logic to_flg;

	logic tx_vld;

	// RX path
	logic rx_wr_en;			// Store window open
	logic rx_wr;
	fifo_dat_t rx_din;
	logic rx_rd;
	fifo_dat_t rx_dout;
	logic rx_de;
	logic [RX_ADR:0] rx_wrds;
	logic rx_ep;
	logic rx_fl;

	// Bus inputs, one register stage
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
		begin
			lb_adr_r <= '0;
			lb_wr_r <= 1'b0;
			lb_rd_r <= 1'b0;
		end
		else
		begin
			lb_adr_r <= lb_adr;
			lb_wr_r <= lb_wr;
			lb_rd_r <= lb_rd;
		end
	end

	always_ff @(posedge CLK_IN)
		lb_din_r <= lb_din;		// Payload

	// Register select
	assign ctl_sel = (lb_adr_r == lb_adr_t'(0));
	assign sta_sel = (lb_adr_r == lb_adr_t'(1));
	assign tx_sel = (lb_adr_r == lb_adr_t'(2));
	assign rx_sel = (lb_adr_r == lb_adr_t'(3));

	// Read mux
	always_comb
	begin
		lb_dout = 32'hdeadcafe;		// Unmapped, write only or empty FIFO
		if (ctl_sel)
			lb_dout = lb_dat_t'(ctl_r);
		else if (sta_sel)
			lb_dout = lb_dat_t'(sta);
		else if (rx_sel && rx_de)
			lb_dout = lb_dat_t'(rx_dout);
	end

	assign lb_vld = lb_rd_r;		// Data ready one cycle after the strobe

	// Control register
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
			ctl_r <= '0;
		else if (ctl_sel && lb_wr_r)
			ctl_r <= lb_din_r[1:0];
	end

	assign run = ctl_r[0];
	assign ie = ctl_r[1];

	// Status word
	assign sta = {rx_wrds, rx_fl, rx_ep, to_flg, irq_r};

	// TX injection, one ring word per bus write
	assign tx_vld = tx_sel && lb_wr_r;
	assign src_vld = tx_vld;
	assign src_som = tx_vld && lb_din_r[17];
	assign src_eom = tx_vld && lb_din_r[16];
	assign src_dat = tx_vld ? lb_din_r[15:0] : '0;

	// Timeout counter and pending flag
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
		begin
			to_cnt <= '0;
			to_end_d <= 1'b1;	// No edge out of reset
			to_en <= 1'b0;
			to_flg <= 1'b0;
		end
		else
		begin
			to_end_d <= to_end;
			if (!run)
			begin
				to_cnt <= '0;
				to_en <= 1'b0;
				to_flg <= 1'b0;
			end
			else
			begin
				if (tx_vld)
					to_cnt <= '1;	// Restart per word
				else if (!to_end)
					to_cnt <= to_cnt - 1'b1;

				if (tx_vld)
					to_en <= 1'b1;
				else if (snk_vld)
					to_en <= 1'b0;	// Something came back

				if (to_en && to_end_re)
					to_flg <= 1'b1;	// Sticky until run drops
			end
		end
	end

	assign to_end = (to_cnt == '0);
	assign to_end_re = to_end && !to_end_d;

	// Reply filter
	// Window opens on a reply header, closes on eom
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
			rx_wr_en <= 1'b0;
		else if (!run)
			rx_wr_en <= 1'b0;
		else if (snk_vld && snk_som && !snk_dat[15])
			rx_wr_en <= 1'b1;
		else if (snk_vld && snk_eom)
			rx_wr_en <= 1'b0;
	end

	assign rx_wr = rx_wr_en && snk_vld && !snk_som;	// Body words only
	assign rx_din = {snk_som, snk_eom, snk_dat};
	assign rx_rd = rx_sel && lb_rd_r && rx_de;		// Pop on bus read

	msg_fifo
	#(
		.ADR_BITS	(RX_ADR)
	)
	rx_fifo_inst
	(
		.RST_IN		(RST_IN),
		.CLK_IN		(CLK_IN),
		.clr		(!run),		// Flushed while stopped
		.wr		(rx_wr),
		.din		(rx_din),
		.rd		(rx_rd),
		.dout		(rx_dout),
		.de		(rx_de),
		.wrds		(rx_wrds),
		.ep		(rx_ep),
		.fl		(rx_fl)
	);

	// Interrupt
	always_ff @(posedge RST_IN, posedge CLK_IN)
	begin
		if (RST_IN)
			irq_r <= 1'b0;
		else
			irq_r <= ie && (!rx_ep || to_flg);
	end

	assign irq = irq_r;

endmodule

// ==== logic/pm_msg_top.sv ====
`timescale 1ns/1ps
`include "pm_msg_params.svh"

module pm_msg_top
(
	input logic RST_IN,
	input logic CLK_IN,
	input pm_msg_pkg::lb_adr_t lb_adr,
	input logic lb_wr,
	input logic lb_rd,
	input pm_msg_pkg::lb_dat_t lb_din,
	output pm_msg_pkg::lb_dat_t lb_dout,
	output logic lb_vld,
	output logic irq
);
	import pm_msg_pkg::*;

	// Ring links, entry 0 from the port, last entry back to it
	logic lnk_vld [`PM_MSG_NODES+1];
	logic lnk_som [`PM_MSG_NODES+1];
	logic lnk_eom [`PM_MSG_NODES+1];
	msg_dat_t lnk_dat [`PM_MSG_NODES+1];

	pm_msg_port port_inst
	(
		.RST_IN		(RST_IN),
		.CLK_IN		(CLK_IN),
		.lb_adr		(lb_adr),
		.lb_wr		(lb_wr),
		.lb_rd		(lb_rd),
		.lb_din		(lb_din),
		.lb_dout	(lb_dout),
		.lb_vld		(lb_vld),
		.src_vld	(lnk_vld[0]),
		.src_som	(lnk_som[0]),
		.src_eom	(lnk_eom[0]),
		.src_dat	(lnk_dat[0]),
		.snk_vld	(lnk_vld[`PM_MSG_NODES]),	// Closes the ring
		.snk_som	(lnk_som[`PM_MSG_NODES]),
		.snk_eom	(lnk_eom[`PM_MSG_NODES]),
		.snk_dat	(lnk_dat[`PM_MSG_NODES]),
		.irq		(irq)
	);

	// Node chain
	for (genvar i = 0; i < `PM_MSG_NODES; i++)
	begin : gen_node
		msg_node #(.ID(i)) node_inst
		(
			.RST_IN (RST_IN), .CLK_IN (CLK_IN),
			.in_vld (lnk_vld[i]), .in_som (lnk_som[i]),
			.in_eom (lnk_eom[i]), .in_dat (lnk_dat[i]),
			.out_vld (lnk_vld[i+1]), .out_som (lnk_som[i+1]),
			.out_eom (lnk_eom[i+1]), .out_dat (lnk_dat[i+1])
		);
	end

endmodule

// ==== tests/pm_msg_sva.sv ====
`timescale 1ns/1ps

module pm_msg_sva
(
	input logic RST_IN,
	input logic CLK_IN,
	input pm_msg_pkg::lb_adr_t lb_adr,
	input logic lb_rd,
	input pm_msg_pkg::lb_dat_t lb_dout,
	input logic lb_vld,
	input logic irq,
	input logic ie		// Interrupt enable inside the port
);
	int fails = 0;		// Failed assertion count

	// Read data one cycle after the strobe, never otherwise
	vld_after_rd: assert property (@(posedge CLK_IN) disable iff (RST_IN) lb_rd |=> lb_vld)
	else
	begin
		fails++;
		$error("lb_vld missing one cycle after lb_rd");
	end

	no_stray_vld: assert property (@(posedge CLK_IN) disable iff (RST_IN) !lb_rd |=> !lb_vld)
	else
	begin
		fails++;
		$error("lb_vld without a preceding lb_rd");
	end

	irq_masked: assert property (@(posedge CLK_IN) disable iff (RST_IN) !ie |=> !irq)
	else
	begin
		fails++;
		$error("irq high with interrupt enable low");
	end

	outs_known: assert property (@(posedge CLK_IN) disable iff (RST_IN)
		!$isunknown({lb_vld, irq}) && (!lb_vld || !$isunknown(lb_dout)))
	else
	begin
		fails++;
		$error("unknown value on a top-level output");
	end

	// Status bit 3 is FIFO full
	never_full: assert property (@(posedge CLK_IN) disable iff (RST_IN)
		lb_rd && lb_adr == 3'd1 |=> !lb_dout[3])
	else
	begin
		fails++;
		$error("status reports the RX FIFO full");
	end

endmodule

bind pm_msg_top pm_msg_sva sva_inst
(
	.RST_IN		(RST_IN),
	.CLK_IN		(CLK_IN),
	.lb_adr		(lb_adr),
	.lb_rd		(lb_rd),
	.lb_dout	(lb_dout),
	.lb_vld		(lb_vld),
	.irq		(irq),
	.ie		(port_inst.ie)
);

// ==== tests/pm_msg_tb.sv ====
`timescale 1ns/1ps
`include "pm_msg_params.svh"

module pm_msg_tb;
	import pm_msg_pkg::*;

	localparam int NODES = `PM_MSG_NODES;
	localparam int REGS = `PM_MSG_NODE_REGS;
	localparam int POLLS = (1 << `PM_MSG_TO_BITS) + 32;	// Status polls before giving up
	localparam logic [31:0] POLY = 32'h80200003;		// Galois taps 32,22,2,1

	logic RST_IN;
	logic CLK_IN;
	lb_adr_t lb_adr;
	logic lb_wr;
	logic lb_rd;
	lb_dat_t lb_din;
	lb_dat_t lb_dout;
	logic lb_vld;
	logic irq;

	logic [31:0] lfsr = 32'h1445;
	msg_dat_t model [NODES][REGS];	// Expected node registers
	int errs;
	int test_errs;			// Errors before the current test
	int checks;
	lb_dat_t rd_dat;
	node_id_t ids [$];		// Outstanding read requests, in order
	reg_adr_t adrs [$];

	pm_msg_top pm_msg_top_inst
	(
		.RST_IN		(RST_IN),
		.CLK_IN		(CLK_IN),
		.lb_adr		(lb_adr),
		.lb_wr		(lb_wr),
		.lb_rd		(lb_rd),
		.lb_din		(lb_din),
		.lb_dout	(lb_dout),
		.lb_vld		(lb_vld),
		.irq		(irq)
	);

	initial
	begin
		CLK_IN = 1'b0;
		forever #50 CLK_IN = ~CLK_IN;	// 100 ns period
	end

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic b;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			b = lfsr[0];
			lfsr = (lfsr >> 1) ^ (b ? POLY : 32'h0);
			r = {r[30:0], b};
		end
		return r;
	endfunction

	task automatic expect_value(input string name, input lb_dat_t exp, input lb_dat_t got);
		checks++;
		assert (got === exp)
		else
		begin
			$display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
			errs++;
		end
	endtask

	task automatic expect_true(input logic cond, input string what);
		checks++;
		assert (cond === 1'b1)
		else
		begin
			$display("%s", what);
			errs++;
		end
	endtask

	// Bus tasks start and end 5 ns after a rising edge
	task automatic bus_write(input lb_adr_t adr, input lb_dat_t dat);
		lb_adr = adr;
		lb_din = dat;
		lb_wr = 1'b1;
		@(posedge CLK_IN);
		#5;
		lb_wr = 1'b0;
	endtask

	task automatic bus_read(input lb_adr_t adr, output lb_dat_t dat);
		int n;
		lb_adr = adr;
		lb_rd = 1'b1;
		@(posedge CLK_IN);
		#5;
		lb_rd = 1'b0;
		n = 0;
		while (!lb_vld && n < 8)
		begin
			@(posedge CLK_IN);
			#5;
			n++;
		end
		expect_true(lb_vld, "no lb_vld after a bus read");
		dat = lb_dout;
	endtask

	// Header then body, back to back
	task automatic send_request(input logic wr, input node_id_t id, input reg_adr_t adr,
		input msg_dat_t body);
		bus_write(3'd2, {14'b0, 2'b10, 1'b1, wr, id, adr});
		bus_write(3'd2, {14'b0, 2'b01, body});
	endtask

	task automatic poll_status(input lb_dat_t mask, input lb_dat_t value, input string what);
		lb_dat_t sta;
		int polls;
		polls = 0;
		bus_read(3'd1, sta);
		while ((sta & mask) != value && polls < POLLS)
		begin
			bus_read(3'd1, sta);
			polls++;
		end
		expect_true((sta & mask) == value, what);
	endtask

	// Reply body only, so som clear and eom set
	task automatic read_reply(input node_id_t id, input reg_adr_t adr);
		lb_dat_t dat;
		bus_read(3'd3, dat);
		expect_value("lb_dout", {14'b0, 2'b01, model[int'(id)][int'(adr)]}, dat);
	endtask

	task automatic wait_irq(input logic level);
		int n;
		n = 0;
		while (irq !== level && n < 16)
		begin
			@(posedge CLK_IN);
			#5;
			n++;
		end
		expect_true(irq === level, level ? "irq did not rise" : "irq did not fall");
	endtask

	task automatic report_test(input string name);
		if (errs == test_errs)
			$display("test %s: ok", name);
		else
			$display("test %s: %0d errors", name, errs - test_errs);
		test_errs = errs;
	endtask

	initial
	begin
		node_id_t id;
		reg_adr_t adr;
		msg_dat_t dat;
		RST_IN = 1'b1;
		lb_adr = '0;
		lb_wr = 1'b0;
		lb_rd = 1'b0;
		lb_din = '0;
		errs = 0;
		test_errs = 0;
		checks = 0;
		for (int n = 0; n < NODES; n++)
			for (int r = 0; r < REGS; r++)
				model[n][r] = '0;	// Registers reset to zero
		repeat (2) @(posedge CLK_IN);
		#5;
		RST_IN = 1'b0;

		expect_value("lb_vld", 32'h0, 32'(lb_vld));
		expect_value("irq", 32'h0, 32'(irq));
		bus_read(3'd0, rd_dat);
		expect_value("control", 32'h0, rd_dat);
		bus_read(3'd1, rd_dat);
		expect_value("status", 32'h4, rd_dat);	// Empty, zero words
		report_test("after reset");

		bus_write(3'd0, 32'h1);		// Run
		for (int i = 0; i < 6; i++)
		begin
			id = node_id_t'(rand_bits(2));
			adr = reg_adr_t'(rand_bits(2));
			dat = msg_dat_t'(rand_bits(16));
			send_request(1'b1, id, adr, dat);
			model[int'(id)][int'(adr)] = dat;
			ids.push_back(id);
			adrs.push_back(adr);
		end
		while (ids.size() > 0)
		begin
			id = ids.pop_front();
			adr = adrs.pop_front();
			send_request(1'b0, id, adr, 16'h0);
			poll_status(32'h3f0, 32'h10, "reply never reached the RX FIFO");
			read_reply(id, adr);
		end
		report_test("read-back");

		id = node_id_t'(rand_bits(2));
		adr = reg_adr_t'(rand_bits(2));
		dat = msg_dat_t'(rand_bits(16));
		send_request(1'b1, id, adr, dat);
		model[int'(id)][int'(adr)] = dat;
		send_request(1'b0, node_id_t'(NODES) + node_id_t'(rand_bits(5)), 8'h0, 16'h0);
		send_request(1'b1, node_id_t'(NODES) + node_id_t'(rand_bits(5)), 8'h1, 16'h0);
		repeat ((1 << `PM_MSG_TO_BITS) + NODES + 4) @(posedge CLK_IN);	// Past any timeout
		#5;
		bus_read(3'd1, rd_dat);
		expect_value("status", 32'h4, rd_dat);
		report_test("discarded puts");

		id = node_id_t'(rand_bits(2));
		adr = reg_adr_t'(REGS) + reg_adr_t'(rand_bits(7));	// Beyond the register file
		send_request(1'b0, id, adr, 16'h0);
		poll_status(32'h2, 32'h2, "timeout flag never set for a dropped read");
		bus_write(3'd0, 32'h0);
		poll_status(32'h2, 32'h0, "timeout flag not cleared when run dropped");
		bus_read(3'd1, rd_dat);
		expect_value("status", 32'h4, rd_dat);
		bus_write(3'd0, 32'h1);
		report_test("timeout");

		bus_write(3'd0, 32'h3);		// Run and interrupt enable
		id = node_id_t'(rand_bits(2));
		adr = reg_adr_t'(rand_bits(2));
		send_request(1'b0, id, adr, 16'h0);
		poll_status(32'h3f0, 32'h10, "reply never reached the RX FIFO");
		wait_irq(1'b1);
		read_reply(id, adr);
		wait_irq(1'b0);
		bus_write(3'd0, 32'h1);
		report_test("interrupt");

		for (int i = 0; i < NODES; i++)
		begin
			id = node_id_t'(rand_bits(2));
			adr = reg_adr_t'(rand_bits(2));
			send_request(1'b0, id, adr, 16'h0);	// All words back to back
			ids.push_back(id);
			adrs.push_back(adr);
		end
		poll_status(32'h3f0, lb_dat_t'(NODES << 4), "not every reply reached the RX FIFO");
		while (ids.size() > 0)
			read_reply(ids.pop_front(), adrs.pop_front());
		report_test("in-flight requests");

		$display("checks %0d, errors %0d, assertion failures %0d", checks, errs,
			pm_msg_top_inst.sva_inst.fails);
		if (errs == 0 && pm_msg_top_inst.sva_inst.fails == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule
